// ==== logic/dma_config.svh ====
`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Memory word address width
`define DMA_ADDR_W 16

// Memory data width
`define DMA_DATA_W 32

// Word count per transfer
`define DMA_LEN_W 8

// Prefetch FIFO entries per channel, power of two
`define DMA_FIFO_DEPTH 4

// FIFO pointer width, log2 of the depth
`define DMA_FIFO_AW 2

// Peer read channels sharing the memory bus
`define DMA_NUM_CH 2

// Register port address, top bit picks the channel
`define DMA_REG_ADDR_W 3

`endif

// ==== logic/dma_pkg.sv ====
package dma_pkg;

	`include "dma_config.svh"

	typedef logic [`DMA_ADDR_W-1:0] addr_t;
	typedef logic [`DMA_DATA_W-1:0] data_t;
	typedef logic [`DMA_LEN_W-1:0] len_t;
	typedef logic [`DMA_REG_ADDR_W-1:0] reg_addr_t;

	// One bit covers both channels
	typedef logic ch_id_t;

	// Host access on the register port
	typedef struct packed {
		logic write;
		reg_addr_t addr;
		data_t wdata;
	} reg_req_t;

	// Per-channel setup from the register block
	typedef struct packed {
		addr_t src;
		len_t len;
		logic start; // Single cycle
	} ch_cfg_t;

	// Single-word read request
	typedef struct packed {
		addr_t addr;
	} mem_req_t;

	// Fetch side of a read channel
	typedef enum logic [1:0] {
		st_idle,
		st_request,
		st_wait_ack,
		st_release
	} ch_state_t;

endpackage

// ==== logic/dma_regs.sv ====
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_regs (
	input  logic clk,
	input  logic reset,
	input  logic reg_req,
	input  dma_pkg::reg_req_t reg_cmd,
	output logic reg_ack,
	output dma_pkg::data_t reg_rdata,
	input  logic [`DMA_NUM_CH-1:0] ch_busy,
	output dma_pkg::ch_cfg_t ch_cfg [`DMA_NUM_CH]
);

	dma_pkg::addr_t src_q [`DMA_NUM_CH];
	dma_pkg::len_t len_q [`DMA_NUM_CH];
	dma_pkg::ch_id_t sel;
	logic [1:0] reg_sel;
	logic access;
	logic start_wr;

	// Request seen but not yet answered
	assign access = reg_req && !reg_ack;
	assign sel = reg_cmd.addr[`DMA_REG_ADDR_W-1];
	assign reg_sel = reg_cmd.addr[1:0];
	assign start_wr = access && reg_cmd.write && reg_sel == 2'd2 && reg_cmd.wdata[0];

	// Ack follows req by one edge in both directions
	always_ff @(posedge clk) begin
		if (reset) begin
			reg_ack <= 1'b0;
		end else begin
			reg_ack <= reg_req;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `DMA_NUM_CH; i++) begin
				src_q[i] <= '0;
				len_q[i] <= '0;
			end
		end else if (access && reg_cmd.write) begin
			case (reg_sel)
				2'd0: src_q[sel] <= reg_cmd.wdata[`DMA_ADDR_W-1:0];
				2'd1: len_q[sel] <= reg_cmd.wdata[`DMA_LEN_W-1:0];
				default: ; // Control handled by the start pulse
			endcase
		end
	end

	// Read data captured on the access edge, held while ack is high
	always_ff @(posedge clk) begin
		if (access) begin
			case (reg_sel)
				2'd0: reg_rdata <= dma_pkg::data_t'(src_q[sel]);
				2'd1: reg_rdata <= dma_pkg::data_t'(len_q[sel]);
				2'd3: reg_rdata <= dma_pkg::data_t'(ch_busy[sel]); // Status, bit 0 busy
				default: reg_rdata <= '0;
			endcase
		end
	end

	for (genvar c = 0; c < `DMA_NUM_CH; c++) begin : g_cfg
		logic start_c;

		// A busy channel ignores start
		assign start_c = start_wr && sel == dma_pkg::ch_id_t'(c) && !ch_busy[c];
		assign ch_cfg[c] = '{src: src_q[c], len: len_q[c], start: start_c};
	end

endmodule

// ==== logic/dma_read_channel.sv ====
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_read_channel (
	input  logic clk,
	input  logic reset,
	input  dma_pkg::ch_cfg_t cfg,
	output logic busy,
	output logic mem_req,
	output dma_pkg::mem_req_t mem_addr,
	input  logic mem_ack,
	input  dma_pkg::data_t mem_rdata,
	output logic out_req,
	input  logic out_ack,
	output dma_pkg::data_t out_data
);

	dma_pkg::ch_state_t state;
	dma_pkg::addr_t addr_q; // Next word to fetch
	dma_pkg::len_t count_q; // Words not yet fetched

	dma_pkg::data_t fifo_mem [`DMA_FIFO_DEPTH];
	logic [`DMA_FIFO_AW-1:0] wr_ptr;
	logic [`DMA_FIFO_AW-1:0] rd_ptr;
	logic [`DMA_FIFO_AW:0] fifo_cnt;
	logic fifo_full;
	logic push;
	logic pop;

	assign fifo_full = fifo_cnt == (`DMA_FIFO_AW+1)'(`DMA_FIFO_DEPTH);
	assign push = state == dma_pkg::st_wait_ack && mem_ack; // Returned word
	assign pop = out_req && out_ack; // Consumer took the head
	assign mem_addr = '{addr: addr_q};
	assign out_data = fifo_mem[rd_ptr];

	// Fetch FSM, one word per memory transaction
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= dma_pkg::st_idle;
			mem_req <= 1'b0;
			addr_q <= '0;
			count_q <= '0;
		end else begin
			// Only accepted while not busy, so never during a fetch
			if (cfg.start) begin
				addr_q <= cfg.src;
				count_q <= cfg.len;
			end
			case (state)
				dma_pkg::st_idle: begin
					if (count_q != '0) begin
						state <= dma_pkg::st_request;
					end
				end
				dma_pkg::st_request: begin
					if (count_q == '0) begin
						state <= dma_pkg::st_idle;
					end else if (!fifo_full) begin
						mem_req <= 1'b1;
						state <= dma_pkg::st_wait_ack;
					end
				end
				dma_pkg::st_wait_ack: begin
					if (mem_ack) begin
						mem_req <= 1'b0;
						addr_q <= addr_q + 1'b1;
						count_q <= count_q - 1'b1;
						state <= dma_pkg::st_release;
					end
				end
				dma_pkg::st_release: begin
					// Wait for ack to fall, then go again right away if possible
					if (!mem_ack) begin
						if (count_q != '0 && !fifo_full) begin
							mem_req <= 1'b1;
							state <= dma_pkg::st_wait_ack;
						end else begin
							state <= dma_pkg::st_request;
						end
					end
				end
				default: state <= dma_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			fifo_mem[wr_ptr] <= mem_rdata;
		end
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: fifo_cnt <= fifo_cnt + 1'b1;
				2'b01: fifo_cnt <= fifo_cnt - 1'b1;
				default: ;
			endcase
		end
	end

	// Out port, next word only after the consumer dropped ack
	always_ff @(posedge clk) begin
		if (reset) begin
			out_req <= 1'b0;
		end else if (pop) begin
			out_req <= 1'b0;
		end else if (!out_req && !out_ack && fifo_cnt != '0) begin
			out_req <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
		end else if (cfg.start) begin
			busy <= cfg.len != '0; // Zero length finishes at once
		end else if (pop && fifo_cnt == 1 && count_q == '0) begin
			busy <= 1'b0; // Last word handed out
		end
	end

	a_no_push_full: assert property (@(posedge clk) disable iff (reset)
		push |-> !fifo_full)
		else $error("read channel pushed into a full FIFO");

	a_addr_stable: assert property (@(posedge clk) disable iff (reset)
		mem_req && !mem_ack |=> $stable(mem_addr))
		else $error("read channel changed mem_addr before mem_ack");

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ps
`include "dma_config.svh"

module mem_arbiter (
	input  logic clk,
	input  logic reset,
	input  logic [`DMA_NUM_CH-1:0] ch_req,
	input  dma_pkg::mem_req_t ch_addr [`DMA_NUM_CH],
	output logic [`DMA_NUM_CH-1:0] ch_ack,
	output dma_pkg::data_t ch_rdata [`DMA_NUM_CH],
	output logic mem_req,
	output dma_pkg::mem_req_t mem_addr,
	input  logic mem_ack,
	input  dma_pkg::data_t mem_rdata
);

	dma_pkg::ch_id_t gnt; // Current owner, or last winner once released
	dma_pkg::ch_id_t pick;
	logic gnt_valid;

	// The other channel wins a tie
	always_comb begin
		pick = ~gnt;
		if (!ch_req[~gnt]) begin
			pick = gnt;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			gnt_valid <= 1'b0;
			gnt <= '0;
		end else if (!gnt_valid) begin
			if (|ch_req) begin
				gnt_valid <= 1'b1;
				gnt <= pick;
			end
		end else if (!ch_req[gnt] && !mem_ack) begin
			gnt_valid <= 1'b0; // Four-phase cycle complete
		end
	end

	assign mem_req = gnt_valid && ch_req[gnt];
	assign mem_addr = ch_addr[gnt];

	for (genvar c = 0; c < `DMA_NUM_CH; c++) begin : g_route
		logic owner;

		assign owner = gnt_valid && gnt == dma_pkg::ch_id_t'(c);
		assign ch_ack[c] = owner && mem_ack;
		assign ch_rdata[c] = owner ? mem_rdata : '0;
	end

	// A fresh ack lands only on a channel that is still asking
	a_ack_to_req: assert property (@(posedge clk) disable iff (reset)
		(ch_ack & ~$past(ch_ack) & ~ch_req) == '0)
		else $error("memory ack routed to a channel that was not requesting");

endmodule

// ==== logic/dma_top.sv ====
`timescale 1ns/1ps
`include "dma_config.svh"

module dma_top (
	input  logic clk,
	input  logic reset,
	// Host register port
	input  logic reg_req,
	input  dma_pkg::reg_req_t reg_cmd,
	output logic reg_ack,
	output dma_pkg::data_t reg_rdata,
	// Shared memory bus
	output logic mem_req,
	output dma_pkg::mem_req_t mem_addr,
	input  logic mem_ack,
	input  dma_pkg::data_t mem_rdata,
	// One consumer port per channel
	output logic [`DMA_NUM_CH-1:0] out_req,
	input  logic [`DMA_NUM_CH-1:0] out_ack,
	output dma_pkg::data_t out_data [`DMA_NUM_CH]
);

	dma_pkg::ch_cfg_t ch_cfg [`DMA_NUM_CH];
	logic [`DMA_NUM_CH-1:0] ch_busy;
	logic [`DMA_NUM_CH-1:0] ch_mem_req;
	logic [`DMA_NUM_CH-1:0] ch_mem_ack;
	dma_pkg::mem_req_t ch_mem_addr [`DMA_NUM_CH];
	dma_pkg::data_t ch_mem_rdata [`DMA_NUM_CH];

	dma_regs u_regs (
		.clk(clk),
		.reset(reset),
		.reg_req(reg_req),
		.reg_cmd(reg_cmd),
		.reg_ack(reg_ack),
		.reg_rdata(reg_rdata),
		.ch_busy(ch_busy),
		.ch_cfg(ch_cfg)
	);

	for (genvar c = 0; c < `DMA_NUM_CH; c++) begin : g_ch
		dma_read_channel u_chan (
			.clk(clk),
			.reset(reset),
			.cfg(ch_cfg[c]),
			.busy(ch_busy[c]),
			.mem_req(ch_mem_req[c]),
			.mem_addr(ch_mem_addr[c]),
			.mem_ack(ch_mem_ack[c]),
			.mem_rdata(ch_mem_rdata[c]),
			.out_req(out_req[c]),
			.out_ack(out_ack[c]),
			.out_data(out_data[c])
		);
	end

	mem_arbiter u_arb (
		.clk(clk),
		.reset(reset),
		.ch_req(ch_mem_req),
		.ch_addr(ch_mem_addr),
		.ch_ack(ch_mem_ack),
		.ch_rdata(ch_mem_rdata),
		.mem_req(mem_req),
		.mem_addr(mem_addr),
		.mem_ack(mem_ack),
		.mem_rdata(mem_rdata)
	);

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// Reset spans the first four rising edges
	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// ==== test/tb_checker.sv ====
`timescale 1ns/1ps
`include "dma_config.svh"

module tb_checker (
	input  logic clk,
	input  logic reset,
	input  logic reg_ack,
	input  dma_pkg::data_t reg_rdata,
	input  logic mem_req,
	input  logic [`DMA_NUM_CH-1:0] out_req,
	input  logic [`DMA_NUM_CH-1:0] out_ack,
	input  dma_pkg::data_t out_data [`DMA_NUM_CH],
	input  logic exp_load, // Row about to start
	input  dma_pkg::ch_id_t exp_ch,
	input  dma_pkg::addr_t exp_src,
	input  dma_pkg::len_t exp_len,
	input  logic rd_check,
	input  dma_pkg::data_t rd_expect,
	input  logic report,
	input  int timeouts,
	output int error_count
);

	dma_pkg::addr_t next_addr [`DMA_NUM_CH];
	dma_pkg::len_t left [`DMA_NUM_CH]; // Words still owed
	logic reset_d;
	logic ack_d;
	logic reported = 1'b0;
	int errors = 0;
	int words = 0;
	int reads = 0;

	assign error_count = errors;

	task automatic check_value(input string name, input dma_pkg::data_t got,
			input dma_pkg::data_t exp);
		if (got !== exp) begin
			$display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	always @(posedge clk) begin
		reset_d <= reset;
		ack_d <= reg_ack;
		if (reset) begin
			for (int c = 0; c < `DMA_NUM_CH; c++) begin
				left[c] <= '0;
			end
		end else begin
			if (reset_d) begin
				// First edge out of reset
				check_value("out_req", dma_pkg::data_t'(out_req), '0);
				check_value("mem_req", dma_pkg::data_t'(mem_req), '0);
				check_value("reg_ack", dma_pkg::data_t'(reg_ack), '0);
			end
			for (int c = 0; c < `DMA_NUM_CH; c++) begin
				if (out_req[c] && out_ack[c]) begin
					if (left[c] == '0) begin
						$display("channel %0d handed out a word nobody asked for at %0t ns",
							c, $time);
						errors++;
					end else begin
						// Memory word is the inverted address over the address
						check_value($sformatf("out_data[%0d]", c), out_data[c],
							{~next_addr[c], next_addr[c]});
						next_addr[c] <= next_addr[c] + 1'b1;
						left[c] <= left[c] - 1'b1;
						words++;
					end
				end
			end
			if (exp_load) begin
				if (left[exp_ch] != '0) begin
					$display("channel %0d still owed %0d words when reloaded at %0t ns",
						exp_ch, left[exp_ch], $time);
					errors++;
				end
				next_addr[exp_ch] <= exp_src;
				left[exp_ch] <= exp_len;
			end
			if (rd_check && reg_ack && !ack_d) begin
				check_value("reg_rdata", reg_rdata, rd_expect);
				reads++;
			end
			if (report && !reported) begin
				for (int c = 0; c < `DMA_NUM_CH; c++) begin
					if (left[c] != '0) begin
						$display("channel %0d never delivered its last %0d words", c, left[c]);
						errors++;
					end
				end
				$display("checker: %0d words, %0d register reads, %0d errors, %0d timeouts",
					words, reads, errors, timeouts);
				reported <= 1'b1;
			end
		end
	end

endmodule

// ==== test/tb_dma.sv ====
`timescale 1ns/1ps
`include "dma_config.svh"

module tb_dma;

	localparam int num_rows = 7;
	localparam int ack_limit = 40; // Edges per register handshake phase
	localparam int poll_limit = 200; // Status reads per channel

	typedef struct packed {
		dma_pkg::ch_id_t ch;
		dma_pkg::addr_t src;
		dma_pkg::len_t len;
		logic slow; // Long consumer delays
		logic restart; // Second start while busy
		logic wait_done; // Poll both channels idle afterwards
	} row_t;

	row_t rows [num_rows] = '{
		'{1'b0, 16'h0100, 8'd5, 1'b0, 1'b0, 1'b1},
		'{1'b0, 16'h4000, 8'd7, 1'b0, 1'b0, 1'b0}, // Back to back with the next row
		'{1'b1, 16'h4005, 8'd7, 1'b0, 1'b0, 1'b1},
		'{1'b1, 16'h8000, 8'd10, 1'b1, 1'b0, 1'b1}, // FIFO fills up
		'{1'b0, 16'hfffe, 8'd8, 1'b0, 1'b1, 1'b1}, // Address wraps
		'{1'b0, 16'h1234, 8'd12, 1'b1, 1'b0, 1'b0},
		'{1'b1, 16'h00ff, 8'd9, 1'b0, 1'b0, 1'b1}
	};

	logic clk;
	logic reset;
	logic reg_req;
	dma_pkg::reg_req_t reg_cmd;
	logic reg_ack;
	dma_pkg::data_t reg_rdata;
	logic mem_req;
	dma_pkg::mem_req_t mem_addr;
	logic mem_ack = 1'b0;
	dma_pkg::data_t mem_rdata = '0;
	logic [`DMA_NUM_CH-1:0] out_req;
	logic [`DMA_NUM_CH-1:0] out_ack = '0;
	dma_pkg::data_t out_data [`DMA_NUM_CH];

	logic exp_load;
	dma_pkg::ch_id_t exp_ch;
	dma_pkg::addr_t exp_src;
	dma_pkg::len_t exp_len;
	logic rd_check;
	dma_pkg::data_t rd_expect;
	logic report;
	int timeouts;
	int error_count;

	logic [15:0] lfsr = 16'd5041;
	logic mem_busy = 1'b0;
	logic [4:0] mem_wait;
	logic [`DMA_NUM_CH-1:0] cons_busy = '0;
	logic [4:0] cons_wait [`DMA_NUM_CH];
	logic [`DMA_NUM_CH-1:0] slow;

	tb_clock u_clock (.*);
	dma_top dut (.*);
	tb_checker u_checker (.*);

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [4:0] rand_bits(input int n);
		logic [4:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[3:0], fb};
		end
		return r;
	endfunction

	// Memory responder and per-channel consumers
	always @(posedge clk) begin
		if (reset) begin
			mem_ack <= 1'b0;
			mem_busy <= 1'b0;
			out_ack <= '0;
			cons_busy <= '0;
		end else begin
			if (mem_ack) begin
				if (!mem_req) begin
					mem_ack <= 1'b0;
				end
			end else if (mem_busy) begin
				if (mem_wait == '0) begin
					mem_ack <= 1'b1;
					mem_rdata <= {~mem_addr.addr, mem_addr.addr};
					mem_busy <= 1'b0;
				end else begin
					mem_wait <= mem_wait - 1'b1;
				end
			end else if (mem_req) begin
				mem_busy <= 1'b1;
				mem_wait <= rand_bits(2); // 1 to 4 cycles
			end
			for (int c = 0; c < `DMA_NUM_CH; c++) begin
				if (out_ack[c]) begin
					if (!out_req[c]) begin
						out_ack[c] <= 1'b0;
					end
				end else if (cons_busy[c]) begin
					if (cons_wait[c] == '0) begin
						out_ack[c] <= 1'b1;
						cons_busy[c] <= 1'b0;
					end else begin
						cons_wait[c] <= cons_wait[c] - 1'b1;
					end
				end else if (out_req[c]) begin
					cons_busy[c] <= 1'b1;
					cons_wait[c] <= slow[c] ? 5'd8 + rand_bits(4) : rand_bits(2);
				end
			end
		end
	end

	task automatic wait_reg_ack(input logic level);
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (reg_ack !== level && n < ack_limit);
		if (reg_ack !== level) begin
			$display("timeout: reg_ack did not go to %0b within %0d cycles", level, ack_limit);
			timeouts++;
		end
	endtask

	// One four-phase register access
	task automatic reg_access(input logic is_write, input dma_pkg::ch_id_t ch,
			input logic [1:0] sel, input dma_pkg::data_t wdata, output dma_pkg::data_t rdata);
		rdata = '0;
		if (timeouts != 0) begin
			return;
		end
		@(posedge clk);
		reg_cmd <= '{write: is_write, addr: {ch, sel}, wdata: wdata};
		reg_req <= 1'b1;
		wait_reg_ack(1'b1);
		rdata = reg_rdata;
		reg_req <= 1'b0;
		rd_check <= 1'b0;
		wait_reg_ack(1'b0);
	endtask

	task automatic write_reg(input dma_pkg::ch_id_t ch, input logic [1:0] sel,
			input dma_pkg::data_t data);
		dma_pkg::data_t unused;
		reg_access(1'b1, ch, sel, data, unused);
	endtask

	// Read whose data the checker compares
	task automatic check_reg(input dma_pkg::ch_id_t ch, input logic [1:0] sel,
			input dma_pkg::data_t value);
		dma_pkg::data_t unused;
		rd_expect <= value;
		rd_check <= 1'b1;
		reg_access(1'b0, ch, sel, '0, unused);
	endtask

	task automatic wait_idle(input dma_pkg::ch_id_t ch);
		dma_pkg::data_t status;
		int polls;
		status = '1;
		polls = 0;
		while (status[0] && polls < poll_limit && timeouts == 0) begin
			reg_access(1'b0, ch, 2'd3, '0, status);
			polls++;
		end
		if (status[0] && timeouts == 0) begin
			$display("timeout: channel %0d still busy after %0d status reads", ch, poll_limit);
			timeouts++;
		end
	endtask

	task automatic run_row(input row_t row);
		slow[row.ch] <= row.slow;
		write_reg(row.ch, 2'd0, dma_pkg::data_t'(row.src));
		write_reg(row.ch, 2'd1, dma_pkg::data_t'(row.len));
		check_reg(row.ch, 2'd0, dma_pkg::data_t'(row.src));
		check_reg(row.ch, 2'd1, dma_pkg::data_t'(row.len));
		@(posedge clk);
		exp_ch <= row.ch;
		exp_src <= row.src;
		exp_len <= row.len;
		exp_load <= 1'b1;
		@(posedge clk);
		exp_load <= 1'b0;
		write_reg(row.ch, 2'd2, 32'd1);
		if (row.restart) begin
			write_reg(row.ch, 2'd2, 32'd1); // Lands while busy
		end
		if (row.wait_done) begin
			for (int c = 0; c < `DMA_NUM_CH; c++) begin
				wait_idle(dma_pkg::ch_id_t'(c));
			end
		end
	endtask

	initial begin
		int n;
		reg_req = 1'b0;
		reg_cmd = '0;
		exp_load = 1'b0;
		exp_ch = '0;
		exp_src = '0;
		exp_len = '0;
		rd_check = 1'b0;
		rd_expect = '0;
		report = 1'b0;
		slow = '0;
		timeouts = 0;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (reset !== 1'b0 && n < 20);
		if (reset !== 1'b0) begin
			$display("timeout: reset was never released");
			timeouts++;
		end
		for (int c = 0; c < `DMA_NUM_CH; c++) begin
			check_reg(dma_pkg::ch_id_t'(c), 2'd3, '0); // Idle after reset
		end
		for (int r = 0; r < num_rows && timeouts == 0; r++) begin
			run_row(rows[r]);
		end
		@(posedge clk);
		report <= 1'b1;
		repeat (2) @(posedge clk);
		if (error_count == 0 && timeouts == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+logic
logic/dma_pkg.sv
logic/dma_regs.sv
logic/dma_read_channel.sv
logic/mem_arbiter.sv
logic/dma_top.sv
test/tb_clock.sv
test/tb_checker.sv
test/tb_dma.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_dma
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
PASS_MSG ?= *** PASSED ***

SOURCES := $(shell grep -v '^+' $(FLIST)) $(wildcard logic/*.svh)
SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
